// ==== src/keystream_packer.sv ====
// keystream packer: collects lane bits into a 64-bit block, first bit ends in bit 0
`default_nettype none

`include "trivium_defines.svh"

module keystream_packer (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            shift,
    input  wire logic [`TRIVIUM_LANES-1:0]       lanes,
    output logic      [`TRIVIUM_BLOCK_WIDTH-1:0] block_o,
    output logic                                 block_full
);

    localparam int SHIFTS = `TRIVIUM_BLOCK_WIDTH / `TRIVIUM_LANES;
    localparam int CNT_W  = (SHIFTS > 1) ? $clog2(SHIFTS) : 1;

    logic [`TRIVIUM_BLOCK_WIDTH-1:0] block_d;
    logic [CNT_W-1:0]                shift_cnt;
    logic                            last_shift;

    // older bits move down, lane 0 lands lowest of the new group
    always_comb begin
        block_d = block_o >> `TRIVIUM_LANES;
        block_d[`TRIVIUM_BLOCK_WIDTH-1 -: `TRIVIUM_LANES] = lanes;
    end

    always_ff @(posedge clk) begin
        if (shift) begin
            block_o <= block_d;
        end
    end

    assign last_shift = (shift_cnt == CNT_W'(SHIFTS - 1));
    assign block_full = shift && last_shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            shift_cnt <= '0;
        end else if (shift) begin
            if (last_shift) begin
                shift_cnt <= '0;  // wrap for the next block
            end else begin
                shift_cnt <= shift_cnt + 1'b1;
            end
        end
    end

    // a full block closes a burst of back-to-back shifts
    full_with_shift : assert property (
        @(posedge clk) disable iff (rst) block_full |-> shift && $past(shift, SHIFTS - 1)
    ) else $error("block_full without a full burst of shifts");

    // a burst of shifts always begins on a block boundary
    burst_aligned : assert property (
        @(posedge clk) disable iff (rst) $rose(shift) |-> (shift_cnt == '0)
    ) else $error("shift burst started mid-block");

endmodule : keystream_packer

`default_nettype wire

// ==== src/trivium_defines.svh ====
// trivium defines: widths, warm-up length and steps per clock for the keystream generator
`ifndef TRIVIUM_DEFINES_SVH
`define TRIVIUM_DEFINES_SVH

// key and iv are the same width in trivium
`define TRIVIUM_KEY_WIDTH 80

// keystream bits per output block
`define TRIVIUM_BLOCK_WIDTH 64

// 4 * 288 steps are discarded before the first keystream bit
`define TRIVIUM_WARMUP_STEPS 1152

// cipher steps per clock, must divide 64 (and 1152)
`define TRIVIUM_LANES 4

`endif

// ==== src/trivium_pkg.sv ====
// trivium package: 288-bit state union and control FSM encoding
`default_nettype none

package trivium_pkg;

    // bit 0 of flat is cipher position s1
    typedef union packed {
        logic [287:0] flat;
        struct packed {
            logic [110:0] reg_c;  // s178..s288
            logic [83:0]  reg_b;  // s94..s177
            logic [92:0]  reg_a;  // s1..s93
        } regs;
    } trivium_state_u;

    typedef enum logic [1:0] {
        warm_up        = 2'd0,
        generate_block = 2'd1,
        hold_block     = 2'd2
    } ctrl_state_e;

endpackage : trivium_pkg

`default_nettype wire

// ==== src/trivium_state_reg.sv ====
// trivium state register: key/iv load under reset, chain feedback and warm-up count
`default_nettype none

`include "trivium_defines.svh"

module trivium_state_reg (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic [`TRIVIUM_KEY_WIDTH-1:0] key,
    input  wire logic [`TRIVIUM_KEY_WIDTH-1:0] iv,
    input  wire logic                          advance,
    input  wire trivium_pkg::trivium_state_u   state_d,
    output trivium_pkg::trivium_state_u        state_q,
    output logic                               warm_done
);

    localparam int WARM_CYCLES = `TRIVIUM_WARMUP_STEPS / `TRIVIUM_LANES;
    localparam int CNT_W       = $clog2(WARM_CYCLES + 1);

    trivium_pkg::trivium_state_u load_state;
    logic [CNT_W-1:0]            warm_cnt;

    // s1..s80 <- key, s94..s173 <- iv, s286..s288 set, rest clear
    always_comb begin
        load_state.flat          = '0;
        load_state.flat[79:0]    = key;
        load_state.flat[172:93]  = iv;
        load_state.flat[287:285] = 3'b111;
    end

    // key and iv are sampled on every reset cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= load_state;
        end else if (advance) begin
            state_q <= state_d;  // end of the step chain
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            warm_cnt <= '0;
        end else if (advance && !warm_done) begin
            warm_cnt <= warm_cnt + 1'b1;  // saturates at WARM_CYCLES
        end
    end

    assign warm_done = (warm_cnt == CNT_W'(WARM_CYCLES));

    // once warmed up the stream position is only lost through a reset
    warm_done_sticky : assert property (
        @(posedge clk) $fell(warm_done) |-> $past(rst)
    ) else $error("warm_done dropped without reset");

endmodule : trivium_state_reg

`default_nettype wire

// ==== src/trivium_step.sv ====
// trivium step: one combinational cipher round, one keystream bit plus next state
`default_nettype none

module trivium_step (
    input  wire trivium_pkg::trivium_state_u state_in,
    output trivium_pkg::trivium_state_u      state_out,
    output logic                             z
);

    logic t1;
    logic t2;
    logic t3;
    logic t1_fb;
    logic t2_fb;
    logic t3_fb;

    // register index = cipher position minus the register's first position
    always_comb begin
        t1 = state_in.regs.reg_a[65] ^ state_in.regs.reg_a[92];   // s66, s93
        t2 = state_in.regs.reg_b[68] ^ state_in.regs.reg_b[83];   // s162, s177
        t3 = state_in.regs.reg_c[65] ^ state_in.regs.reg_c[110];  // s243, s288

        z = t1 ^ t2 ^ t3;

        t1_fb = t1 ^ (state_in.regs.reg_a[90] & state_in.regs.reg_a[91])
                   ^ state_in.regs.reg_b[77];                     // s171
        t2_fb = t2 ^ (state_in.regs.reg_b[81] & state_in.regs.reg_b[82])
                   ^ state_in.regs.reg_c[86];                     // s264
        t3_fb = t3 ^ (state_in.regs.reg_c[108] & state_in.regs.reg_c[109])
                   ^ state_in.regs.reg_a[68];                     // s69

        // each register moves up one position, feedback enters at the bottom
        state_out.regs.reg_a = {state_in.regs.reg_a[91:0], t3_fb};
        state_out.regs.reg_b = {state_in.regs.reg_b[82:0], t1_fb};
        state_out.regs.reg_c = {state_in.regs.reg_c[109:0], t2_fb};
    end

endmodule : trivium_step

`default_nettype wire

// ==== src/trivium_wrapper.sv ====
// trivium wrapper: control FSM around a multi-lane step chain, state register and packer
`default_nettype none

`include "trivium_defines.svh"

module trivium_wrapper (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic [`TRIVIUM_KEY_WIDTH-1:0]   key,
    input  wire logic [`TRIVIUM_KEY_WIDTH-1:0]   iv,
    input  wire logic                            next_data,
    output logic                                 end_block,
    output logic      [`TRIVIUM_BLOCK_WIDTH-1:0] block_o
);

    trivium_pkg::ctrl_state_e    ctrl_q;
    trivium_pkg::ctrl_state_e    ctrl_d;
    trivium_pkg::trivium_state_u state_q;
    trivium_pkg::trivium_state_u state_d;
    trivium_pkg::trivium_state_u chain [`TRIVIUM_LANES+1];
    logic [`TRIVIUM_LANES-1:0]   lanes;
    logic                        advance;
    logic                        shift;
    logic                        warm_done;
    logic                        block_full;

    trivium_state_reg u_state_reg (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .iv        (iv),
        .advance   (advance),
        .state_d   (state_d),
        .state_q   (state_q),
        .warm_done (warm_done)
    );

    // lane i is step i of this cycle, lower lanes come first in the stream
    assign chain[0] = state_q;

    for (genvar i = 0; i < `TRIVIUM_LANES; i++) begin : g_lane
        trivium_step u_step (
            .state_in  (chain[i]),
            .state_out (chain[i+1]),
            .z         (lanes[i])
        );
    end

    assign state_d = chain[`TRIVIUM_LANES];

    keystream_packer u_packer (
        .clk        (clk),
        .rst        (rst),
        .shift      (shift),
        .lanes      (lanes),
        .block_o    (block_o),
        .block_full (block_full)
    );

    always_comb begin
        ctrl_d = ctrl_q;
        case (ctrl_q)
            trivium_pkg::warm_up: begin
                if (warm_done) begin
                    ctrl_d = trivium_pkg::generate_block;
                end
            end
            trivium_pkg::generate_block: begin
                if (block_full) begin
                    ctrl_d = trivium_pkg::hold_block;
                end
            end
            trivium_pkg::hold_block: begin
                if (next_data) begin
                    ctrl_d = trivium_pkg::generate_block;
                end
            end
            default: begin
                ctrl_d = trivium_pkg::warm_up;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q <= trivium_pkg::warm_up;
        end else begin
            ctrl_q <= ctrl_d;
        end
    end

    // warm-up stops stepping once the counter saturates, one idle cycle before output
    assign advance   = ((ctrl_q == trivium_pkg::warm_up) && !warm_done) ||
                       (ctrl_q == trivium_pkg::generate_block);
    assign shift     = (ctrl_q == trivium_pkg::generate_block);
    assign end_block = (ctrl_q == trivium_pkg::hold_block);

    // a held block is always the one the packer just completed
    end_after_full : assert property (
        @(posedge clk) disable iff (rst)
        $rose(end_block) |-> !shift && $past(block_full)
    ) else $error("end_block rose without a completed block");

endmodule : trivium_wrapper

`default_nettype wire

// ==== tests/tb_trivium_wrapper.sv ====
// trivium wrapper testbench: bit-level cipher model, key/iv case table, latency and block checks
`default_nettype none

`include "trivium_defines.svh"

module tb_trivium_wrapper;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int KW         = `TRIVIUM_KEY_WIDTH;
    localparam int BW         = `TRIVIUM_BLOCK_WIDTH;
    localparam int WARMUP     = `TRIVIUM_WARMUP_STEPS;
    localparam int FIRST_LAT  = (WARMUP + BW) / `TRIVIUM_LANES + 1;
    localparam int NEXT_LAT   = BW / `TRIVIUM_LANES + 1;
    localparam int NUM_CASES  = 5;
    localparam int MAX_BLOCKS = 8;
    localparam int WAIT_LIMIT = 2 * FIRST_LAT;

    logic          clk;
    logic          rst;
    logic [KW-1:0] key;
    logic [KW-1:0] iv;
    logic          next_data;
    logic          end_block;
    logic [BW-1:0] block_o;

    string         case_name   [NUM_CASES];
    logic [KW-1:0] case_key    [NUM_CASES];
    logic [KW-1:0] case_iv     [NUM_CASES];
    int            case_blocks [NUM_CASES];
    int            case_delay  [NUM_CASES];  // hold cycles before each next_data

    logic          ks [BW*MAX_BLOCKS];  // model keystream, first bit after warm-up at 0
    integer        seed;
    int            errors;
    int            tests_failed;

    trivium_wrapper DUT (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .iv        (iv),
        .next_data (next_data),
        .end_block (end_block),
        .block_o   (block_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #1;  // outputs settled, inputs change here
    endtask

    // positions s[1]..s[288] as in the cipher description
    task automatic model_keystream(input logic [KW-1:0] k, input logic [KW-1:0] v,
                                   input int nbits);
        logic [1:288] s;
        logic         t1;
        logic         t2;
        logic         t3;
        logic         z;
        s = '0;
        for (int i = 1; i <= KW; i++) begin
            s[i]      = k[i-1];
            s[93 + i] = v[i-1];
        end
        s[286] = 1'b1;
        s[287] = 1'b1;
        s[288] = 1'b1;
        for (int n = 0; n < WARMUP + nbits; n++) begin
            t1 = s[66] ^ s[93];
            t2 = s[162] ^ s[177];
            t3 = s[243] ^ s[288];
            z  = t1 ^ t2 ^ t3;
            t1 = t1 ^ (s[91] & s[92]) ^ s[171];
            t2 = t2 ^ (s[175] & s[176]) ^ s[264];
            t3 = t3 ^ (s[286] & s[287]) ^ s[69];
            s  = {t3, s[1:92], t1, s[94:176], t2, s[178:287]};
            if (n >= WARMUP) begin
                ks[n - WARMUP] = z;
            end
        end
    endtask

    function automatic logic [BW-1:0] expected_block(input int b);
        logic [BW-1:0] blk;
        for (int i = 0; i < BW; i++) begin
            blk[i] = ks[b*BW + i];  // earliest bit lands in bit 0
        end
        return blk;
    endfunction

    task automatic reset_dut(input logic [KW-1:0] k, input logic [KW-1:0] v);
        rst       = 1'b1;
        key       = k;
        iv        = v;
        next_data = 1'b0;
        repeat (16) tick();
        rst = 1'b0;
    endtask

    // next_data is high for cycles in [pulse_lo, pulse_hi) while end_block is low
    task automatic wait_end_block(input int limit, input int pulse_lo, input int pulse_hi,
                                  output int cycles, output bit timed_out);
        cycles = 0;
        do begin
            tick();
            cycles++;
            next_data = (cycles >= pulse_lo) && (cycles < pulse_hi) && !end_block;
        end while (!end_block && cycles < limit);
        timed_out = !end_block;
    endtask

    task automatic fill_table();
        logic [95:0] r;
        case_name[0] = "zero_key_iv";
        case_key[0]  = '0;
        case_iv[0]   = '0;
        case_delay[0] = 0;
        case_name[1] = "key_bit0";
        case_key[1]  = KW'(1);
        case_iv[1]   = '0;
        case_delay[1] = 7;
        case_name[2] = "iv_bit79";
        case_key[2]  = '0;
        case_iv[2]   = KW'(1) << (KW - 1);
        case_delay[2] = 40;
        for (int c = 3; c < NUM_CASES; c++) begin
            case_name[c] = (c == 3) ? "random_a" : "random_b";
            r = {$random(seed), $random(seed), $random(seed)};
            case_key[c] = r[KW-1:0];
            r = {$random(seed), $random(seed), $random(seed)};
            case_iv[c] = r[KW-1:0];
            case_delay[c] = $unsigned($random(seed)) % 41;
        end
        for (int c = 0; c < NUM_CASES; c++) begin
            case_blocks[c] = 5;  // first block plus four requested ones
        end
    endtask

    task automatic run_case(input int idx);
        int            cycles;
        bit            timed_out;
        int            start_errors;
        logic [BW-1:0] held;
        start_errors = errors;
        model_keystream(case_key[idx], case_iv[idx], case_blocks[idx] * BW);
        reset_dut(case_key[idx], case_iv[idx]);
        // next_data pulses during warm-up must be ignored
        wait_end_block(WAIT_LIMIT, 10, 13, cycles, timed_out);
        if (timed_out) begin
            $display("%s: end_block never rose within %0d cycles after reset",
                     case_name[idx], WAIT_LIMIT);
            errors++;
        end else if (cycles != FIRST_LAT) begin
            $display("ERROR %s first_block_latency expected %0d actual %0d",
                     case_name[idx], FIRST_LAT, cycles);
            errors++;
        end
        for (int b = 0; b < case_blocks[idx] && !timed_out; b++) begin
            if (b > 0) begin
                held = block_o;
                for (int d = 0; d < case_delay[idx]; d++) begin
                    tick();
                    if (!end_block || block_o !== held) begin
                        $display("%s: block %0d not held steady while next_data was low",
                                 case_name[idx], b - 1);
                        errors++;
                    end
                end
                next_data = 1'b1;
                wait_end_block(4 * NEXT_LAT, 0, 0, cycles, timed_out);
                if (timed_out) begin
                    $display("%s: end_block never returned after next_data for block %0d",
                             case_name[idx], b);
                    errors++;
                end else if (cycles != NEXT_LAT) begin
                    $display("ERROR %s block%0d_latency expected %0d actual %0d",
                             case_name[idx], b, NEXT_LAT, cycles);
                    errors++;
                end
            end
            if (!timed_out && block_o !== expected_block(b)) begin
                $display("ERROR %s block%0d expected %h actual %h",
                         case_name[idx], b, expected_block(b), block_o);
                errors++;
            end
        end
        // leave the DUT mid-block so the next reset interrupts a running stream
        next_data = 1'b1;
        tick();
        next_data = 1'b0;
        repeat (5) tick();
        if (errors == start_errors) begin
            $display("PASS %s", case_name[idx]);
        end else begin
            $display("FAIL %s with %0d errors", case_name[idx], errors - start_errors);
            tests_failed++;
        end
    endtask

    initial begin
        rst          = 1'b1;
        key          = '0;
        iv           = '0;
        next_data    = 1'b0;
        seed         = 74;
        errors       = 0;
        tests_failed = 0;
        fill_table();
        for (int c = 0; c < NUM_CASES; c++) begin
            run_case(c);
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 NUM_CASES, NUM_CASES - tests_failed, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_trivium_wrapper

`default_nettype wire

// ==== trivium_stream.f ====
+incdir+src
src/trivium_pkg.sv
src/trivium_step.sv
src/trivium_state_reg.sv
src/keystream_packer.sv
src/trivium_wrapper.sv
tests/tb_trivium_wrapper.sv
